//--- Bender.yml
package:
  name: fma_fp32

sources:
  - files:
      - hdl/fp32_pkg.sv
      - hdl/fma_op_pkg.sv
      - hdl/fma_unpack.sv
      - hdl/mant_mul_seq.sv
      - hdl/fma_core.sv
      - hdl/fma_round.sv
      - hdl/fma_top.sv
  - target: test
    files:
      - testbench/fma_chk.sv
      - testbench/fma_tb.sv

//--- hdl/fma_core.sv
//////////////////////////////
// fma processing FSM
// align, signed add,
// leading-zero normalize
//////////////////////////////

`timescale 1ns/100ps

module fma_core (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush_i,
    input  logic                         valid_i,
    input  logic                         sign_p_i,
    input  logic signed [9:0]            exp_p_i,
    input  logic [fp32_pkg::SIG_W-1:0]   sig_a_i,
    input  logic [fp32_pkg::SIG_W-1:0]   sig_b_i,
    input  logic                         sign_c_i,
    input  logic signed [9:0]            exp_c_i,
    input  logic [fp32_pkg::SIG_W-1:0]   sig_c_i,
    input  logic                         special_i,
    input  logic [31:0]                  special_res_i,
    input  logic                         special_nv_i,
    input  logic                         mul_valid_i,
    input  logic [2*fp32_pkg::SIG_W-1:0] mul_prod_i,
    output logic                         mul_start_o,
    output logic [fp32_pkg::SIG_W-1:0]   mul_a_o,
    output logic [fp32_pkg::SIG_W-1:0]   mul_b_o,
    output logic                         valid_o,
    output logic                         sign_o,
    output logic signed [9:0]            exp_o,
    output logic [fp32_pkg::SIG_W+2:0]   sig_o,
    output logic                         special_o,
    output logic [31:0]                  special_res_o,
    output logic                         special_nv_o
);

    // state names the register stage that is currently loaded
    typedef enum logic [2:0] {IDLE, MUL_WAIT, ALIGN, ADD, NORM} state_t;

    state_t                         state_q;
    logic                           sign_p_q;
    logic                           sign_c_q;
    logic signed [9:0]              exp_p_q;
    logic signed [9:0]              exp_c_q;
    logic signed [9:0]              exp_q;
    logic [fp32_pkg::SIG_W-1:0]     sig_c_q;
    logic [fma_op_pkg::SUM_W-1:0]   prod_al_q;
    logic [fma_op_pkg::SUM_W-1:0]   add_al_q;
    logic [fma_op_pkg::SUM_W-1:0]   mag_q;
    logic                           sign_q;
    logic signed [10:0]             exp_diff;
    logic [10:0]                    abs_diff;
    logic [6:0]                     shamt;
    logic [fma_op_pkg::SUM_W-1:0]   prod_ext;
    logic [fma_op_pkg::SUM_W-1:0]   add_ext;
    logic [fma_op_pkg::SUM_W-1:0]   sum_c;
    logic [6:0]                     lz;
    logic [fma_op_pkg::SUM_W-1:0]   norm_sh;

    function automatic logic [fma_op_pkg::SUM_W-1:0] shr_sticky(
        input logic [fma_op_pkg::SUM_W-1:0] v,
        input logic [6:0]                   sh
    );
        logic [fma_op_pkg::SUM_W-1:0] lost;
        lost = v & ~({fma_op_pkg::SUM_W{1'b1}} << sh);
        return (v >> sh) | {{(fma_op_pkg::SUM_W-1){1'b0}}, |lost};
    endfunction

    // both terms have their leading one at bit SUM_W-4 when exponents match
    assign prod_ext = {2'b00, mul_prod_i, {(fma_op_pkg::SUM_W-2-2*fp32_pkg::SIG_W){1'b0}}};
    assign add_ext  = {3'b000, sig_c_q, {(fma_op_pkg::SUM_W-3-fp32_pkg::SIG_W){1'b0}}};
    assign exp_diff = {exp_p_q[9], exp_p_q} - {exp_c_q[9], exp_c_q};
    assign abs_diff = exp_diff[10] ? -exp_diff : exp_diff;
    assign shamt    = (abs_diff > 11'(fma_op_pkg::SUM_W - 1)) ? 7'(fma_op_pkg::SUM_W - 1) :
                      abs_diff[6:0];

    assign sum_c = (sign_p_q ? -prod_al_q : prod_al_q) + (sign_c_q ? -add_al_q : add_al_q);

    // priority loop, highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < fma_op_pkg::SUM_W - 1; i++) begin
            if (mag_q[i]) begin
                lz = 7'(fma_op_pkg::SUM_W - 2 - i);
            end
        end
    end

    assign norm_sh = mag_q << lz;
    assign valid_o = (state_q == NORM);

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            state_q     <= IDLE;
            mul_start_o <= 1'b0;
        end else begin
            mul_start_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (valid_i) begin
                        state_q     <= MUL_WAIT;
                        mul_start_o <= 1'b1;
                    end
                end
                MUL_WAIT: begin
                    if (mul_valid_i) begin
                        state_q <= ALIGN;
                    end
                end
                ALIGN:   state_q <= ADD;
                ADD:     state_q <= NORM;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: begin
                if (valid_i) begin
                    sign_p_q      <= sign_p_i;
                    exp_p_q       <= exp_p_i;
                    mul_a_o       <= sig_a_i;
                    mul_b_o       <= sig_b_i;
                    sign_c_q      <= sign_c_i;
                    exp_c_q       <= exp_c_i;
                    sig_c_q       <= sig_c_i;
                    special_o     <= special_i;
                    special_res_o <= special_res_i;
                    special_nv_o  <= special_nv_i;
                end
            end
            MUL_WAIT: begin
                // smaller exponent term moves right
                if (mul_valid_i) begin
                    prod_al_q <= exp_diff[10] ? shr_sticky(prod_ext, shamt) : prod_ext;
                    add_al_q  <= exp_diff[10] ? add_ext : shr_sticky(add_ext, shamt);
                    exp_q     <= exp_diff[10] ? exp_c_q : exp_p_q;
                end
            end
            ALIGN: begin
                mag_q  <= sum_c[fma_op_pkg::SUM_W-1] ? -sum_c : sum_c;
                // exact zero is negative only if both terms were
                sign_q <= (sum_c == '0) ? (sign_p_q & sign_c_q) : sum_c[fma_op_pkg::SUM_W-1];
            end
            ADD: begin
                sign_o <= sign_q;
                exp_o  <= (mag_q == '0) ? 10'sd0 : exp_q + 10'sd2 - $signed({3'b000, lz});
                sig_o  <= {norm_sh[fma_op_pkg::SUM_W-2 -: fp32_pkg::SIG_W+2],
                           |norm_sh[fma_op_pkg::SUM_W-fp32_pkg::SIG_W-4:0]};
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/fma_op_pkg.sv
//////////////////////////////
// fma operation encoding
// flag bit positions
// latency and datapath sizes
//////////////////////////////

package fma_op_pkg;

    typedef enum logic [2:0] {
        FMADD  = 3'd0,
        FMSUB  = 3'd1,
        FNMADD = 3'd2,
        FNMSUB = 3'd3,
        FADD   = 3'd4,
        FSUB   = 3'd5,
        FMUL   = 3'd6
    } fma_op_t;

    localparam int FLAG_NV = 2;
    localparam int FLAG_OF = 1;
    localparam int FLAG_NX = 0;

    localparam int MUL_CYCLES  = 24;
    // unpack, mul start, align, add, normalize and round around the multiplier
    localparam int FMA_LATENCY = MUL_CYCLES + 6;

    // 48 product bits, 26 guard bits, carry and sign on top
    localparam int SUM_W = 48 + 26 + 2;

endpackage

//--- hdl/fma_round.sv
//////////////////////////////
// fma output stage
// nearest-even rounding,
// range checks, packing
//////////////////////////////

`timescale 1ns/100ps

module fma_round (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush_i,
    input  logic                       valid_i,
    input  logic                       sign_i,
    input  logic signed [9:0]          exp_i,
    input  logic [fp32_pkg::SIG_W+2:0] sig_i,
    input  logic                       special_i,
    input  logic [31:0]                special_res_i,
    input  logic                       special_nv_i,
    output logic                       done_o,
    output logic [31:0]                result_o,
    output logic [2:0]                 flags_o
);

    logic [fp32_pkg::SIG_W-1:0] mant;
    logic                       guard_b;
    logic                       round_b;
    logic                       sticky_b;
    logic                       rnd_up;
    logic [fp32_pkg::SIG_W:0]   mant_r;
    logic signed [9:0]          exp_r;
    logic [31:0]                res;
    logic [2:0]                 flg;

    assign mant     = sig_i[fp32_pkg::SIG_W+2:3];
    assign guard_b  = sig_i[2];
    assign round_b  = sig_i[1];
    assign sticky_b = sig_i[0];
    assign rnd_up   = guard_b & (round_b | sticky_b | mant[0]);
    assign mant_r   = {1'b0, mant} + rnd_up;
    // a carry out leaves a zero fraction, only the exponent moves
    assign exp_r    = exp_i + $signed({9'b0, mant_r[fp32_pkg::SIG_W]});

    always_comb begin
        res = '0;
        flg = '0;
        if (special_i) begin
            res = special_res_i;
            flg[fma_op_pkg::FLAG_NV] = special_nv_i;
        end else if (exp_r >= fp32_pkg::EXP_MAX) begin
            res = {sign_i, 8'hff, {fp32_pkg::MAN_W{1'b0}}};
            flg[fma_op_pkg::FLAG_OF] = 1'b1;
            flg[fma_op_pkg::FLAG_NX] = 1'b1;
        end else if (exp_r <= 0) begin
            // flush to zero, an exact zero sum raises nothing
            res = {sign_i, 31'b0};
            flg[fma_op_pkg::FLAG_NX] = |sig_i;
        end else begin
            res = {sign_i, exp_r[fp32_pkg::EXP_W-1:0], mant_r[fp32_pkg::MAN_W-1:0]};
            flg[fma_op_pkg::FLAG_NX] = guard_b | round_b | sticky_b;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            done_o   <= 1'b0;
            result_o <= '0;
            flags_o  <= '0;
        end else begin
            done_o   <= valid_i;
            result_o <= valid_i ? res : '0;
            flags_o  <= valid_i ? flg : '0;
        end
    end

endmodule

//--- hdl/fma_top.sv
//////////////////////////////
// binary32 fused
// multiply-add top level
//////////////////////////////

`timescale 1ns/100ps

module fma_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  fma_op_pkg::fma_op_t op_i,
    input  logic [31:0]         a_i,
    input  logic [31:0]         b_i,
    input  logic [31:0]         c_i,
    input  logic                flush_i,
    output logic                busy_o,
    output logic                done_o,
    output logic [31:0]         result_o,
    output logic [2:0]          flags_o
);

    logic                         unpack_valid;
    logic                         sign_p;
    logic signed [9:0]            exp_p;
    logic [fp32_pkg::SIG_W-1:0]   sig_a;
    logic [fp32_pkg::SIG_W-1:0]   sig_b;
    logic                         sign_c;
    logic signed [9:0]            exp_c;
    logic [fp32_pkg::SIG_W-1:0]   sig_c;
    logic                         up_special;
    logic [31:0]                  up_special_res;
    logic                         up_special_nv;
    logic                         mul_start;
    logic                         mul_valid;
    logic [fp32_pkg::SIG_W-1:0]   mul_a;
    logic [fp32_pkg::SIG_W-1:0]   mul_b;
    logic [2*fp32_pkg::SIG_W-1:0] mul_prod;
    logic                         norm_valid;
    logic                         norm_sign;
    logic signed [9:0]            norm_exp;
    logic [fp32_pkg::SIG_W+2:0]   norm_sig;
    logic                         core_special;
    logic [31:0]                  core_special_res;
    logic                         core_special_nv;

    // one request in flight
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            busy_o <= 1'b0;
        end else if (start_i && !busy_o) begin
            busy_o <= 1'b1;
        end else if (done_o) begin
            busy_o <= 1'b0;
        end
    end

    fma_unpack u_unpack (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .op_i         (op_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .c_i          (c_i),
        .flush_i      (flush_i),
        .busy_i       (busy_o),
        .valid_o      (unpack_valid),
        .sign_p_o     (sign_p),
        .exp_p_o      (exp_p),
        .sig_a_o      (sig_a),
        .sig_b_o      (sig_b),
        .sign_c_o     (sign_c),
        .exp_c_o      (exp_c),
        .sig_c_o      (sig_c),
        .special_o    (up_special),
        .special_res_o(up_special_res),
        .special_nv_o (up_special_nv)
    );

    fma_core u_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .valid_i      (unpack_valid),
        .sign_p_i     (sign_p),
        .exp_p_i      (exp_p),
        .sig_a_i      (sig_a),
        .sig_b_i      (sig_b),
        .sign_c_i     (sign_c),
        .exp_c_i      (exp_c),
        .sig_c_i      (sig_c),
        .special_i    (up_special),
        .special_res_i(up_special_res),
        .special_nv_i (up_special_nv),
        .mul_valid_i  (mul_valid),
        .mul_prod_i   (mul_prod),
        .mul_start_o  (mul_start),
        .mul_a_o      (mul_a),
        .mul_b_o      (mul_b),
        .valid_o      (norm_valid),
        .sign_o       (norm_sign),
        .exp_o        (norm_exp),
        .sig_o        (norm_sig),
        .special_o    (core_special),
        .special_res_o(core_special_res),
        .special_nv_o (core_special_nv)
    );

    mant_mul_seq u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush_i(flush_i),
        .start_i(mul_start),
        .a_i    (mul_a),
        .b_i    (mul_b),
        .valid_o(mul_valid),
        .prod_o (mul_prod)
    );

    fma_round u_round (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .valid_i      (norm_valid),
        .sign_i       (norm_sign),
        .exp_i        (norm_exp),
        .sig_i        (norm_sig),
        .special_i    (core_special),
        .special_res_i(core_special_res),
        .special_nv_i (core_special_nv),
        .done_o       (done_o),
        .result_o     (result_o),
        .flags_o      (flags_o)
    );

endmodule

//--- hdl/fma_unpack.sv
//////////////////////////////
// fma input stage
// operand split, classify,
// special result detection
//////////////////////////////

`timescale 1ns/100ps

module fma_unpack (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start_i,
    input  fma_op_pkg::fma_op_t        op_i,
    input  logic [31:0]                a_i,
    input  logic [31:0]                b_i,
    input  logic [31:0]                c_i,
    input  logic                       flush_i,
    input  logic                       busy_i,
    output logic                       valid_o,
    output logic                       sign_p_o,
    output logic signed [9:0]          exp_p_o,
    output logic [fp32_pkg::SIG_W-1:0] sig_a_o,
    output logic [fp32_pkg::SIG_W-1:0] sig_b_o,
    output logic                       sign_c_o,
    output logic signed [9:0]          exp_c_o,
    output logic [fp32_pkg::SIG_W-1:0] sig_c_o,
    output logic                       special_o,
    output logic [31:0]                special_res_o,
    output logic                       special_nv_o
);

    logic [31:0]         b_s;
    logic [31:0]         c_s;
    fp32_pkg::fp_class_t cls_a;
    fp32_pkg::fp_class_t cls_b;
    fp32_pkg::fp_class_t cls_c;
    logic                sign_p;
    logic                sign_c;
    logic                p_inf;
    logic                p_zero;
    logic                c_inf;
    logic                c_zero;
    logic                any_nan;
    logic                any_snan;
    logic                spec;
    logic [31:0]         spec_res;
    logic                spec_nv;
    logic                accept;

    function automatic fp32_pkg::fp_class_t classify(input logic [31:0] x);
        logic [fp32_pkg::EXP_W-1:0] e;
        e = x[fp32_pkg::MAN_W +: fp32_pkg::EXP_W];
        if (e == '0) begin
            return fp32_pkg::FP_ZERO;
        end else if (e != fp32_pkg::EXP_MAX) begin
            return fp32_pkg::FP_NORMAL;
        end else if (x[fp32_pkg::MAN_W-1:0] == '0) begin
            return fp32_pkg::FP_INF;
        end
        return x[fp32_pkg::MAN_W-1] ? fp32_pkg::FP_QNAN : fp32_pkg::FP_SNAN;
    endfunction

    // hidden bit only for normals, everything else reads as zero
    function automatic logic [fp32_pkg::SIG_W-1:0] signif(input logic [31:0] x,
                                                          input fp32_pkg::fp_class_t cls);
        return (cls == fp32_pkg::FP_NORMAL) ? {1'b1, x[fp32_pkg::MAN_W-1:0]} : '0;
    endfunction

    // fadd/fsub run as a*1 +- b, fmul as a*b + signed zero
    always_comb begin
        b_s = b_i;
        c_s = c_i;
        case (op_i)
            fma_op_pkg::FADD, fma_op_pkg::FSUB: begin
                b_s = {1'b0, 8'(fp32_pkg::EXP_BIAS), {fp32_pkg::MAN_W{1'b0}}};
                c_s = b_i;
            end
            fma_op_pkg::FMUL: c_s = {a_i[31] ^ b_i[31], 31'b0};
            default: ;
        endcase
    end

    assign cls_a = classify(a_i);
    assign cls_b = classify(b_s);
    assign cls_c = classify(c_s);

    // fnmadd is -(a*b)+c, fnmsub is -(a*b)-c
    assign sign_p = a_i[31] ^ b_s[31] ^
                    (op_i == fma_op_pkg::FNMADD || op_i == fma_op_pkg::FNMSUB);
    assign sign_c = c_s[31] ^ (op_i == fma_op_pkg::FMSUB || op_i == fma_op_pkg::FNMSUB ||
                               op_i == fma_op_pkg::FSUB);

    assign p_inf    = (cls_a == fp32_pkg::FP_INF) || (cls_b == fp32_pkg::FP_INF);
    assign p_zero   = (cls_a == fp32_pkg::FP_ZERO) || (cls_b == fp32_pkg::FP_ZERO);
    assign c_inf    = (cls_c == fp32_pkg::FP_INF);
    assign c_zero   = (cls_c == fp32_pkg::FP_ZERO);
    assign any_snan = (cls_a == fp32_pkg::FP_SNAN) || (cls_b == fp32_pkg::FP_SNAN) ||
                      (cls_c == fp32_pkg::FP_SNAN);
    assign any_nan  = any_snan || (cls_a == fp32_pkg::FP_QNAN) ||
                      (cls_b == fp32_pkg::FP_QNAN) || (cls_c == fp32_pkg::FP_QNAN);

    always_comb begin
        spec     = 1'b1;
        spec_nv  = 1'b0;
        spec_res = fp32_pkg::QNAN;
        if (any_nan) begin
            spec_nv = any_snan;
        end else if ((p_inf && p_zero) || (p_inf && c_inf && sign_p != sign_c)) begin
            spec_nv = 1'b1;
        end else if (p_inf || c_inf) begin
            spec_res = {p_inf ? sign_p : sign_c, 8'hff, {fp32_pkg::MAN_W{1'b0}}};
        end else if (p_zero && c_zero) begin
            spec_res = {sign_p & sign_c, 31'b0};
        end else begin
            spec = 1'b0;
        end
    end

    assign accept = start_i && !busy_i && !flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= accept;
        end
    end

    // zero operands get an exponent far below any normal term
    always_ff @(posedge clk) begin
        if (accept) begin
            sign_p_o      <= sign_p;
            exp_p_o       <= p_zero ? -10'sd400 :
                             $signed({2'b00, a_i[30:23]} + {2'b00, b_s[30:23]} -
                                     10'(fp32_pkg::EXP_BIAS));
            sig_a_o       <= signif(a_i, cls_a);
            sig_b_o       <= signif(b_s, cls_b);
            sign_c_o      <= sign_c;
            exp_c_o       <= c_zero ? -10'sd400 : $signed({2'b00, c_s[30:23]});
            sig_c_o       <= signif(c_s, cls_c);
            special_o     <= spec;
            special_res_o <= spec_res;
            special_nv_o  <= spec_nv;
        end
    end

endmodule

//--- hdl/fp32_pkg.sv
//////////////////////////////
// binary32 field widths, bias
// and special patterns
// operand class encoding
//////////////////////////////

package fp32_pkg;

    localparam int EXP_W = 8;
    localparam int MAN_W = 23;
    localparam int SIG_W = MAN_W + 1;

    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;

    // canonical quiet nan
    localparam logic [31:0] QNAN = 32'h7fc0_0000;

    // subnormals fold into FP_ZERO
    typedef enum logic [2:0] {
        FP_ZERO   = 3'd0,
        FP_NORMAL = 3'd1,
        FP_INF    = 3'd2,
        FP_QNAN   = 3'd3,
        FP_SNAN   = 3'd4
    } fp_class_t;

endpackage

//--- hdl/mant_mul_seq.sv
//////////////////////////////
// radix-2 shift-add
// unsigned significand
// multiplier
//////////////////////////////

`timescale 1ns/100ps

module mant_mul_seq (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush_i,
    input  logic                         start_i,
    input  logic [fp32_pkg::SIG_W-1:0]   a_i,
    input  logic [fp32_pkg::SIG_W-1:0]   b_i,
    output logic                         valid_o,
    output logic [2*fp32_pkg::SIG_W-1:0] prod_o
);

    logic [fp32_pkg::SIG_W-1:0]         mcand_q;
    logic [$clog2(fp32_pkg::SIG_W)-1:0] cnt_q;
    logic                               run_q;
    logic [fp32_pkg::SIG_W:0]           part_sum;

    // upper half accumulates, lower half holds the multiplier bits
    assign part_sum = {1'b0, prod_o[2*fp32_pkg::SIG_W-1:fp32_pkg::SIG_W]} +
                      (prod_o[0] ? {1'b0, mcand_q} : '0);

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            run_q   <= 1'b0;
            cnt_q   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (start_i) begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end else if (run_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == ($clog2(fp32_pkg::SIG_W))'(fp32_pkg::SIG_W - 1)) begin
                    run_q   <= 1'b0;
                    valid_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand_q <= a_i;
            prod_o  <= {{fp32_pkg::SIG_W{1'b0}}, b_i};
        end else if (run_q) begin
            prod_o  <= {part_sum, prod_o[fp32_pkg::SIG_W-1:1]};
        end
    end

endmodule

//--- tb.f
hdl/fp32_pkg.sv
hdl/fma_op_pkg.sv
hdl/fma_unpack.sv
hdl/mant_mul_seq.sv
hdl/fma_core.sv
hdl/fma_round.sv
hdl/fma_top.sv
testbench/fma_chk.sv
testbench/fma_tb.sv

//--- testbench/fma_chk.sv
//////////////////////////////
// handshake assertions
// bound into fma_top
//////////////////////////////

`timescale 1ns/100ps

module fma_chk (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  logic       flush_i,
    input  logic       busy_i,
    input  logic       done_i,
    input  logic [2:0] flags_i
);

    int   err_cnt = 0;
    logic accepted;

    assign accepted = start_i && !busy_i && !flush_i;

    // done is a single-cycle strobe
    done_strobe: assert property (@(posedge clk) disable iff (!rst_n) done_i |=> !done_i)
        else begin
            $error("done_o high for two cycles in a row");
            err_cnt++;
        end

    // fixed latency unless a flush aborts the request
    done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accepted ##1 (!flush_i)[*fma_op_pkg::FMA_LATENCY] |=> done_i)
        else begin
            $error("done_o missing at the fixed latency after an accepted start");
            err_cnt++;
        end

    flags_idle: assert property (@(posedge clk) disable iff (!rst_n) !done_i |-> flags_i == '0)
        else begin
            $error("flags_o nonzero while done_o is low");
            err_cnt++;
        end

endmodule

bind fma_top fma_chk u_chk (
    .clk    (clk),
    .rst_n  (rst_n),
    .start_i(start_i),
    .flush_i(flush_i),
    .busy_i (busy_o),
    .done_i (done_o),
    .flags_i(flags_o)
);

//--- testbench/fma_tb.sv
//////////////////////////////
// fma_top testbench
// vector table, handshake
// and flush tests
//////////////////////////////

`timescale 1ns/100ps

module fma_tb;

    localparam int NUM_VEC    = 20;
    // four extra slots for the handshake and flush runs
    localparam int MAX_CYCLES = (NUM_VEC + 4) * (fma_op_pkg::FMA_LATENCY + 4) + 100;

    localparam logic [2:0] F_NONE = 3'b000;
    localparam logic [2:0] F_NV   = 3'(1 << fma_op_pkg::FLAG_NV);
    localparam logic [2:0] F_NX   = 3'(1 << fma_op_pkg::FLAG_NX);
    localparam logic [2:0] F_OFNX = 3'(1 << fma_op_pkg::FLAG_OF) | F_NX;

    logic                clk;
    logic                rst_n;
    logic                start_i;
    fma_op_pkg::fma_op_t op_i;
    logic [31:0]         a_i;
    logic [31:0]         b_i;
    logic [31:0]         c_i;
    logic                flush_i;
    logic                busy_o;
    logic                done_o;
    logic [31:0]         result_o;
    logic [2:0]          flags_o;

    fma_op_pkg::fma_op_t vec_op  [NUM_VEC];
    logic [31:0]         vec_a   [NUM_VEC];
    logic [31:0]         vec_b   [NUM_VEC];
    logic [31:0]         vec_c   [NUM_VEC];
    logic [31:0]         vec_res [NUM_VEC];
    logic [2:0]          vec_flg [NUM_VEC];

    integer seed;
    int     cycle_cnt;

    fma_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (start_i),
        .op_i    (op_i),
        .a_i     (a_i),
        .b_i     (b_i),
        .c_i     (c_i),
        .flush_i (flush_i),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .result_o(result_o),
        .flags_o (flags_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped by the cycle limit");
    end

    task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic set_entry(input int idx, input fma_op_pkg::fma_op_t op,
                             input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
                             input logic [31:0] res, input logic [2:0] flg);
        vec_op[idx]  = op;
        vec_a[idx]   = a;
        vec_b[idx]   = b;
        vec_c[idx]   = c;
        vec_res[idx] = res;
        vec_flg[idx] = flg;
    endtask

    // expected patterns worked out by hand
    task automatic load_table();
        // 3 and 5 with addend 2 through every operation
        set_entry(0, fma_op_pkg::FMADD, 'h40400000, 'h40a00000, 'h40000000, 'h41880000, F_NONE);
        set_entry(1, fma_op_pkg::FMSUB, 'h40400000, 'h40a00000, 'h40000000, 'h41500000, F_NONE);
        set_entry(2, fma_op_pkg::FNMADD, 'h40400000, 'h40a00000, 'h40000000, 'hc1500000, F_NONE);
        set_entry(3, fma_op_pkg::FNMSUB, 'h40400000, 'h40a00000, 'h40000000, 'hc1880000, F_NONE);
        set_entry(4, fma_op_pkg::FADD, 'h40400000, 'h40a00000, 'h00000000, 'h41000000, F_NONE);
        set_entry(5, fma_op_pkg::FSUB, 'h40400000, 'h40a00000, 'h00000000, 'hc0000000, F_NONE);
        set_entry(6, fma_op_pkg::FMUL, 'h40400000, 'h40a00000, 'h00000000, 'h41700000, F_NONE);
        // (1+2^-23)^2 - (1+2^-22) leaves 2^-46
        set_entry(7, fma_op_pkg::FMSUB, 'h3f800001, 'h3f800001, 'h3f800002, 'h28800000, F_NONE);
        // 1 + 2^-24 + 2^-47 rounds up
        set_entry(8, fma_op_pkg::FMADD, 'h3f800001, 'h33800000, 'h3f800000, 'h3f800001, F_NX);
        // ties to even round down then up
        set_entry(9, fma_op_pkg::FMADD, 'h3f800000, 'h33800000, 'h3f800000, 'h3f800000, F_NX);
        set_entry(10, fma_op_pkg::FMADD, 'h3f800000, 'h33800000, 'h3f800001, 'h3f800002, F_NX);
        // invalid cases
        set_entry(11, fma_op_pkg::FMADD, 'h7f800000, 'h00000000, 'h3f800000, fp32_pkg::QNAN, F_NV);
        set_entry(12, fma_op_pkg::FMADD, 'h7f800000, 'h3f800000, 'hff800000, fp32_pkg::QNAN, F_NV);
        set_entry(13, fma_op_pkg::FMADD, 'h7f800001, 'h3f800000, 'h3f800000, fp32_pkg::QNAN, F_NV);
        set_entry(14, fma_op_pkg::FMADD, 'h7fc00000, 'h3f800000, 'h3f800000, fp32_pkg::QNAN, F_NONE);
        // 2*3 - inf
        set_entry(15, fma_op_pkg::FMSUB, 'h40000000, 'h40400000, 'h7f800000, 'hff800000, F_NONE);
        // signed zero sums
        set_entry(16, fma_op_pkg::FADD, 'h80000000, 'h80000000, 'h00000000, 'h80000000, F_NONE);
        set_entry(17, fma_op_pkg::FADD, 'h00000000, 'h80000000, 'h00000000, 'h00000000, F_NONE);
        // 2^100 squared and 2^-100 times -2^-100
        set_entry(18, fma_op_pkg::FMUL, 'h71800000, 'h71800000, 'h00000000, 'h7f800000, F_OFNX);
        set_entry(19, fma_op_pkg::FMUL, 'h0d800000, 'h8d800000, 'h00000000, 'h80000000, F_NX);
    endtask

    task automatic drive_req(input int idx);
        @(posedge clk);
        op_i    <= vec_op[idx];
        a_i     <= vec_a[idx];
        b_i     <= vec_b[idx];
        c_i     <= vec_c[idx];
        start_i <= 1'b1;
    endtask

    // counts edges after the sampling edge until done_o shows
    task automatic wait_done(output int edges);
        edges = 0;
        @(negedge clk);
        while (!done_o) begin
            expect_equal(busy_o, 1'b1, "busy_o while an operation runs");
            @(negedge clk);
            edges++;
        end
    endtask

    task automatic no_done_for(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk);
            expect_equal(done_o, 1'b0, what);
        end
    endtask

    task automatic run_entry(input int idx);
        int edges;
        drive_req(idx);
        @(posedge clk);
        start_i <= 1'b0;
        wait_done(edges);
        expect_equal(edges, fma_op_pkg::FMA_LATENCY, $sformatf("entry %0d latency", idx));
        expect_equal(result_o, vec_res[idx], $sformatf("entry %0d result", idx));
        expect_equal(flags_o, vec_flg[idx], $sformatf("entry %0d flags", idx));
    endtask

    initial begin
        seed    = 32'h41cf;
        rst_n   = 1'b0;
        start_i = 1'b0;
        op_i    = fma_op_pkg::FMADD;
        a_i     = '0;
        b_i     = '0;
        c_i     = '0;
        flush_i = 1'b0;
        load_table();

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        expect_equal(done_o, 1'b0, "done_o after reset");
        expect_equal(busy_o, 1'b0, "busy_o after reset");
        expect_equal(result_o, '0, "result_o after reset");
        expect_equal(flags_o, '0, "flags_o after reset");

        for (int i = 0; i < NUM_VEC; i++) begin
            run_entry(i);
        end

        // start stays high through the whole run while busy
        drive_req(0);
        @(posedge clk);
        a_i <= $random(seed);
        b_i <= $random(seed);
        c_i <= $random(seed);
        repeat (fma_op_pkg::FMA_LATENCY) @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        expect_equal(done_o, 1'b1, "done_o with start held high");
        expect_equal(result_o, vec_res[0], "result with ignored starts");
        expect_equal(flags_o, vec_flg[0], "flags with ignored starts");
        no_done_for(fma_op_pkg::FMA_LATENCY + 4, "done_o from an ignored start");

        // flush in the middle of the multiply
        drive_req(4);
        @(posedge clk);
        start_i <= 1'b0;
        repeat (10) @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        @(negedge clk);
        expect_equal(busy_o, 1'b0, "busy_o after flush");
        no_done_for(fma_op_pkg::FMA_LATENCY + 4, "done_o after flush");
        run_entry(1);

        if (UUT.u_chk.err_cnt != 0) begin
            $display("%0d handshake assertion failures", UUT.u_chk.err_cnt);
            $display("TEST FAIL");
            $fatal(1, "handshake assertions failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
